/* hw/icache_pkg.sv */
/*
  geometry and shared types for the 4-way instruction cache
  16 sets of 16-byte blocks; fetch addresses are word aligned
  block word i sits at bits [32*i +: 32] of block_t
*/
package icache_pkg;

  localparam int ADDR_W          = 32;
  localparam int WORD_W          = 32;
  localparam int WAYS            = 4;
  localparam int SETS            = 16;
  localparam int WORDS_PER_BLOCK = 4;
  localparam int BLOCK_W         = WORD_W * WORDS_PER_BLOCK;

  // address split is tag | index | word select | byte
  localparam int OFFSET_W = 4;
  localparam int INDEX_W  = 4;
  localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;
  localparam int WAY_W    = 2;
  localparam int PLRU_W   = WAYS - 1;

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [BLOCK_W-1:0]    block_t;
  typedef logic [TAG_W-1:0]      tag_t;
  typedef logic [INDEX_W-1:0]    index_t;
  typedef logic [OFFSET_W-3:0]   word_sel_t;
  typedef logic [WAY_W-1:0]      way_t;
  typedef logic [WAYS-1:0]       way_mask_t;
  typedef logic [PLRU_W-1:0]     plru_t;

  // fetch entry held in TL or TV
  typedef struct packed {
    addr_t addr;
  } fetch_s;

  // one block write seen by tags, data and plru alike
  typedef struct packed {
    logic   we;
    index_t index;
    way_t   way;
    tag_t   tag;
    block_t block;
  } fill_s;

  typedef struct packed {
    logic   rd;
    index_t index;
  } lookup_s;

  typedef enum logic [1:0] {
    s_ready,
    s_req,
    s_release,
    s_replay
  } ctrl_state_e;

endpackage

/* hw/icache_tag_array.sv */
/*
  tag store and valid bits for four ways
  read is registered on lookup_i.rd; compare runs in the TL cycle
  valid bits clear on reset; tags are only meaningful when valid
*/
`timescale 1ns/1ps

module icache_tag_array (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  icache_pkg::lookup_s   lookup_i,
  input  icache_pkg::fill_s     fill_i,
  input  icache_pkg::tag_t      tag_i,
  output icache_pkg::way_mask_t hit_mask_o,
  output icache_pkg::way_mask_t valid_mask_o
);
  import icache_pkg::*;

  tag_t      tag_mem [WAYS][SETS];
  way_mask_t valid_r [SETS];
  tag_t      tag_rd_r [WAYS];
  way_mask_t valid_rd_r;

  always_ff @(posedge clk_i) begin
    for (int w = 0; w < WAYS; w++) begin
      if (lookup_i.rd) begin
        tag_rd_r[w] <= tag_mem[w][lookup_i.index];
      end
      if (fill_i.we && fill_i.way == way_t'(w)) begin
        tag_mem[w][fill_i.index] <= fill_i.tag;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < SETS; s++) begin
        valid_r[s] <= '0;
      end
      valid_rd_r <= '0;
    end else begin
      if (lookup_i.rd) begin
        valid_rd_r <= valid_r[lookup_i.index];
      end
      if (fill_i.we) begin
        valid_r[fill_i.index][fill_i.way] <= 1'b1;
      end
    end
  end

  // per-way compare against the TL tag
  always_comb begin
    for (int w = 0; w < WAYS; w++) begin
      hit_mask_o[w] = valid_rd_r[w] && (tag_rd_r[w] == tag_i);
    end
  end

  assign valid_mask_o = valid_rd_r;

  // fill never duplicates a resident tag within a set
  a_one_hit: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(hit_mask_o));

endmodule

/* hw/icache_data_array.sv */
/*
  four block-wide banks, one per way, indexed by set
  the TV block register holds the hit way, or the fill block on a miss
  fill and lookup must not share a cycle
*/
`timescale 1ns/1ps

module icache_data_array (
  input  logic                  clk_i,
  input  icache_pkg::lookup_s   lookup_i,
  input  icache_pkg::fill_s     fill_i,
  input  icache_pkg::way_mask_t hit_mask_i,
  input  icache_pkg::fetch_s    tv_addr_i,
  input  logic                  miss_fill_i,
  output icache_pkg::word_t     data_o
);
  import icache_pkg::*;

  block_t    bank_mem [WAYS][SETS];
  block_t    rd_r [WAYS];
  block_t    hit_block;
  block_t    tv_block_r;
  word_sel_t word_sel;

  always_ff @(posedge clk_i) begin
    for (int w = 0; w < WAYS; w++) begin
      if (lookup_i.rd) begin
        rd_r[w] <= bank_mem[w][lookup_i.index];
      end
      if (fill_i.we && fill_i.way == way_t'(w)) begin
        bank_mem[w][fill_i.index] <= fill_i.block;
      end
    end
  end

  // one-hot way mux that stays zero on a miss
  always_comb begin
    hit_block = '0;
    for (int w = 0; w < WAYS; w++) begin
      if (hit_mask_i[w]) begin
        hit_block = hit_block | rd_r[w];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_i.we) begin
      tv_block_r <= fill_i.block;
    end else if (!miss_fill_i) begin
      tv_block_r <= hit_block;
    end
  end

  assign word_sel = tv_addr_i.addr[2 +: OFFSET_W-2];
  assign data_o   = tv_block_r[word_sel*WORD_W +: WORD_W];

  a_no_fill_on_read: assert property (@(posedge clk_i)
    !(fill_i.we && lookup_i.rd));

endmodule

/* hw/icache_plru.sv */
/*
  tree pseudo-LRU, three bits per set, cleared on reset
  bit 0 picks the half, bit 1 picks in ways 0-1, bit 2 in ways 2-3
  victim is valid in the TL cycle of the set last looked up
*/
`timescale 1ns/1ps

module icache_plru (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  icache_pkg::lookup_s   lookup_i,
  input  icache_pkg::fill_s     fill_i,
  input  icache_pkg::way_mask_t hit_mask_i,
  output icache_pkg::way_t      victim_way_o
);
  import icache_pkg::*;

  plru_t  bits_r [SETS];
  index_t index_r;
  logic   rd_r;
  way_t   hit_way;
  plru_t  cur;

  // point every node on the path away from way w
  function automatic plru_t touch(plru_t bits, way_t w);
    plru_t upd;
    upd    = bits;
    upd[0] = ~w[1];
    if (w[1]) begin
      upd[2] = ~w[0];
    end else begin
      upd[1] = ~w[0];
    end
    return upd;
  endfunction

  always_comb begin
    hit_way = '0;
    for (int w = 0; w < WAYS; w++) begin
      if (hit_mask_i[w]) begin
        hit_way = way_t'(w);
      end
    end
  end

  assign cur          = bits_r[index_r];
  assign victim_way_o = cur[0] ? {1'b1, cur[2]} : {1'b0, cur[1]};

  always_ff @(posedge clk_i) begin
    if (lookup_i.rd) begin
      index_r <= lookup_i.index;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_r <= 1'b0;
      for (int s = 0; s < SETS; s++) begin
        bits_r[s] <= '0;
      end
    end else begin
      rd_r <= lookup_i.rd;
      if (rd_r && |hit_mask_i) begin
        bits_r[index_r] <= touch(cur, hit_way);
      end
      if (fill_i.we) begin
        bits_r[fill_i.index] <= touch(bits_r[fill_i.index], fill_i.way);
      end
    end
  end

endmodule

/* hw/icache_ctrl.sv */
/*
  TL/TV pipeline and miss sequencing for the instruction cache
  one miss open at a time; the younger TL fetch is held and re-read
  mem_ack_i is assumed low out of reset
*/
`timescale 1ns/1ps

module icache_ctrl (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  fetch_v_i,
  input  icache_pkg::addr_t     fetch_addr_i,
  output logic                  ready_o,
  output logic                  data_v_o,
  input  icache_pkg::way_mask_t hit_mask_i,
  input  icache_pkg::way_mask_t valid_mask_i,
  input  icache_pkg::way_t      victim_way_i,
  output icache_pkg::lookup_s   lookup_o,
  output icache_pkg::fill_s     fill_o,
  output icache_pkg::tag_t      tl_tag_o,
  output icache_pkg::fetch_s    tv_addr_o,
  output logic                  miss_fill_o,
  output logic                  mem_req_o,
  output icache_pkg::addr_t     mem_addr_o,
  input  logic                  mem_ack_i,
  input  icache_pkg::block_t    mem_block_i
);
  import icache_pkg::*;

  ctrl_state_e state_r;
  logic        tl_v_r;
  fetch_s      tl_r;
  logic        tv_v_r;
  fetch_s      tv_r;
  way_mask_t   tv_hit_r;
  way_mask_t   tv_valid_r;
  way_t        tv_victim_r;
  logic        mem_req_r;
  logic        miss;
  logic        advance;
  logic        accept;
  way_t        fill_way;

  assign miss = tv_v_r & ~|tv_hit_r;
  // pipeline only moves in s_ready with no open miss
  assign advance  = (state_r == s_ready) & ~miss;
  assign ready_o  = advance;
  assign accept   = fetch_v_i & advance;
  assign data_v_o = (advance & tv_v_r) | (state_r == s_replay);

  always_comb begin
    lookup_o.rd    = accept;
    lookup_o.index = fetch_addr_i[OFFSET_W +: INDEX_W];
    // re-read the held fetch against the updated arrays
    if (state_r == s_replay) begin
      lookup_o.rd    = tl_v_r;
      lookup_o.index = tl_r.addr[OFFSET_W +: INDEX_W];
    end
  end

  assign tl_tag_o    = tl_r.addr[OFFSET_W+INDEX_W +: TAG_W];
  assign tv_addr_o   = tv_r;
  assign miss_fill_o = (state_r != s_ready);
  assign mem_req_o   = mem_req_r;
  assign mem_addr_o  = {tv_r.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

  // lowest invalid way wins over the plru choice
  always_comb begin
    fill_way = tv_victim_r;
    for (int w = WAYS - 1; w >= 0; w--) begin
      if (!tv_valid_r[w]) begin
        fill_way = way_t'(w);
      end
    end
  end

  assign fill_o.we    = (state_r == s_req) & mem_ack_i;
  assign fill_o.index = tv_r.addr[OFFSET_W +: INDEX_W];
  assign fill_o.way   = fill_way;
  assign fill_o.tag   = tv_r.addr[OFFSET_W+INDEX_W +: TAG_W];
  assign fill_o.block = mem_block_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r   <= s_ready;
      tl_v_r    <= 1'b0;
      tv_v_r    <= 1'b0;
      mem_req_r <= 1'b0;
    end else begin
      case (state_r)
        s_ready: begin
          if (miss) begin
            state_r   <= s_req;
            mem_req_r <= 1'b1;
          end else begin
            tl_v_r <= accept;
            tv_v_r <= tl_v_r;
          end
        end
        s_req: begin
          if (mem_ack_i) begin
            mem_req_r <= 1'b0;
            state_r   <= s_release;
          end
        end
        s_release: begin
          if (!mem_ack_i) begin
            state_r <= s_replay;
          end
        end
        s_replay: begin
          // missed fetch answers this cycle
          tv_v_r  <= 1'b0;
          state_r <= s_ready;
        end
        default: state_r <= s_ready;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance) begin
      if (accept) begin
        tl_r.addr <= fetch_addr_i;
      end
      tv_r        <= tl_r;
      tv_hit_r    <= hit_mask_i;
      tv_valid_r  <= valid_mask_i;
      tv_victim_r <= victim_way_i;
    end
  end

  a_req_held: assert property (@(posedge clk_i) disable iff (reset_i)
    (state_r == s_req && !mem_ack_i) |=> mem_req_o);

  a_addr_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_o |=> (!mem_req_o || $stable(mem_addr_o)));

endmodule

/* hw/icache_top.sv */
/*
  4-way set-associative instruction cache, two-stage lookup
  hit latency is two edges from acceptance; misses stall ready_o
  memory side is a four-phase req/ack returning a full block
*/
`timescale 1ns/1ps

module icache_top (
  input  logic               clk_i,
  input  logic               reset_i,

  input  logic               fetch_v_i,
  input  icache_pkg::addr_t  fetch_addr_i,
  output logic               ready_o,

  output logic               data_v_o,
  output icache_pkg::word_t  data_o,

  output logic               mem_req_o,
  output icache_pkg::addr_t  mem_addr_o,
  input  logic               mem_ack_i,
  input  icache_pkg::block_t mem_block_i
);
  import icache_pkg::*;

  lookup_s   lookup;
  fill_s     fill;
  way_mask_t hit_mask;
  way_mask_t valid_mask;
  way_t      victim_way;
  tag_t      tl_tag;
  fetch_s    tv_addr;
  logic      miss_fill;

  icache_ctrl ctrl_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .fetch_v_i    (fetch_v_i),
    .fetch_addr_i (fetch_addr_i),
    .ready_o      (ready_o),
    .data_v_o     (data_v_o),
    .hit_mask_i   (hit_mask),
    .valid_mask_i (valid_mask),
    .victim_way_i (victim_way),
    .lookup_o     (lookup),
    .fill_o       (fill),
    .tl_tag_o     (tl_tag),
    .tv_addr_o    (tv_addr),
    .miss_fill_o  (miss_fill),
    .mem_req_o    (mem_req_o),
    .mem_addr_o   (mem_addr_o),
    .mem_ack_i    (mem_ack_i),
    .mem_block_i  (mem_block_i)
  );

  icache_tag_array tag_array_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .lookup_i     (lookup),
    .fill_i       (fill),
    .tag_i        (tl_tag),
    .hit_mask_o   (hit_mask),
    .valid_mask_o (valid_mask)
  );

  icache_data_array data_array_i (
    .clk_i       (clk_i),
    .lookup_i    (lookup),
    .fill_i      (fill),
    .hit_mask_i  (hit_mask),
    .tv_addr_i   (tv_addr),
    .miss_fill_i (miss_fill),
    .data_o      (data_o)
  );

  icache_plru plru_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .lookup_i     (lookup),
    .fill_i       (fill),
    .hit_mask_i   (hit_mask),
    .victim_way_o (victim_way)
  );

endmodule

/* tb/tb_clock_gen.sv */
/*
  100 ns free-running clock
  reset is high for the first five rising edges
*/
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (5) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

/* tb/tb_icache.sv */
/*
  directed testbench for the instruction cache
  memory model answers after 1 to 4 cycles; word at A is A ^ 32'h5a5a0000
  inputs change on the falling edge and responses are checked in fetch order
*/
`timescale 1ns/1ps

module tb_icache;
  import icache_pkg::*;

  localparam int    TIMEOUT_CYCLES = 4000;
  localparam word_t MEM_PATTERN    = 32'h5a5a_0000;

  logic   clk;
  logic   reset;
  logic   fetch_v;
  addr_t  fetch_addr;
  logic   ready;
  logic   data_v;
  word_t  data;
  logic   mem_req;
  addr_t  mem_addr;
  logic   mem_ack;
  block_t mem_block;

  // bookkeeping updated on the falling edge
  addr_t  exp_q[$];
  int     cycle;
  int     req_count;
  addr_t  last_req_addr;
  int     last_resp_cycle;
  int     last_accept_cycle;
  integer seed;

  tb_clock_gen clock_gen_i (
    .clk_o   (clk),
    .reset_o (reset)
  );

  icache_top dut_i (
    .clk_i        (clk),
    .reset_i      (reset),
    .fetch_v_i    (fetch_v),
    .fetch_addr_i (fetch_addr),
    .ready_o      (ready),
    .data_v_o     (data_v),
    .data_o       (data),
    .mem_req_o    (mem_req),
    .mem_addr_o   (mem_addr),
    .mem_ack_i    (mem_ack),
    .mem_block_i  (mem_block)
  );

  function automatic word_t mem_word(addr_t a);
    return a ^ MEM_PATTERN;
  endfunction

  function automatic block_t mem_block_at(addr_t base);
    block_t b;
    for (int i = 0; i < WORDS_PER_BLOCK; i++) begin
      b[i*WORD_W +: WORD_W] = mem_word(base + addr_t'(4 * i));
    end
    return b;
  endfunction

  task automatic report_error(input string msg);
    $display("ERROR: %s", msg);
    $display("sim failed");
    $fatal(1, "stopped on error");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("sim failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // protocol monitor, response checker and memory model in one process
  initial begin : bus_and_response
    addr_t a;
    logic  prev_req;
    addr_t prev_addr;
    int    wait_cnt;
    seed = 43;
    mem_ack = 1'b0;
    mem_block = '0;
    cycle = 0;
    req_count = 0;
    last_req_addr = '0;
    last_resp_cycle = 0;
    prev_req = 1'b0;
    prev_addr = '0;
    wait_cnt = 0;
    forever begin
      @(negedge clk);
      cycle++;
      if (cycle > TIMEOUT_CYCLES) begin
        report_error("timeout, the tests did not finish in time");
      end
      if (!reset) begin
        if (prev_req && !mem_req && !mem_ack) begin
          report_error("mem_req_o dropped before mem_ack_i arrived");
        end
        if (!prev_req && mem_req && mem_ack) begin
          report_error("mem_req_o rose while mem_ack_i was still high");
        end
        if (prev_req && mem_req && mem_addr !== prev_addr) begin
          report_error("mem_addr_o changed while mem_req_o was high");
        end
        if (!prev_req && mem_req) begin
          req_count++;
          last_req_addr = mem_addr;
        end
        if (data_v) begin
          if (exp_q.size() == 0) begin
            report_error("data_v_o with no fetch outstanding");
          end
          a = exp_q.pop_front();
          check_eq("data_o", data, mem_word(a));
          last_resp_cycle = cycle;
        end
        // four-phase memory acks after a random delay and releases after req drops
        if (mem_ack) begin
          if (!mem_req) begin
            mem_ack = 1'b0;
          end
        end else if (mem_req) begin
          if (wait_cnt == 0) begin
            wait_cnt = 2 + int'($unsigned($random(seed)) % 4);
          end
          wait_cnt--;
          if (wait_cnt == 0) begin
            mem_block = mem_block_at(mem_addr);
            mem_ack = 1'b1;
          end
        end
      end
      prev_req = mem_req;
      prev_addr = mem_addr;
    end
  end

  // holds the fetch until ready_o and returns just after the accepting edge
  task automatic fetch(input addr_t a);
    @(negedge clk);
    fetch_v = 1'b1;
    fetch_addr = a;
    while (!ready) @(negedge clk);
    @(posedge clk);
    exp_q.push_back(a);
    last_accept_cycle = cycle;
  endtask

  task automatic end_fetch();
    @(negedge clk);
    fetch_v = 1'b0;
  endtask

  task automatic drain();
    end_fetch();
    while (exp_q.size() != 0) @(posedge clk);
  endtask

  task automatic test_reset_state();
    check_eq("ready_o", 32'(ready), 1);
    check_eq("data_v_o", 32'(data_v), 0);
    check_eq("mem_req_o", 32'(mem_req), 0);
  endtask

  task automatic test_cold_miss_then_hit();
    int reqs;
    reqs = req_count;
    fetch(32'h0000_1234);
    drain();
    check_eq("mem_req_o count", req_count - reqs, 1);
    check_eq("mem_addr_o", last_req_addr, 32'h0000_1230);
    reqs = req_count;
    fetch(32'h0000_1238);
    drain();
    check_eq("mem_req_o count", req_count - reqs, 0);
    check_eq("hit latency", last_resp_cycle - last_accept_cycle, 2);
  endtask

  task automatic test_back_to_back();
    addr_t bases[2];
    int    reqs;
    int    prev;
    bases[0] = 32'h0000_1230;
    bases[1] = 32'h0000_2240;
    fetch(32'h0000_2244);
    drain();
    reqs = req_count;
    prev = 0;
    for (int b = 0; b < 2; b++) begin
      for (int i = 0; i < WORDS_PER_BLOCK; i++) begin
        fetch(bases[b] + addr_t'(4 * i));
        if (b != 0 || i != 0) begin
          check_eq("accept spacing", last_accept_cycle - prev, 1);
        end
        prev = last_accept_cycle;
      end
    end
    drain();
    check_eq("mem_req_o count", req_count - reqs, 0);
  endtask

  task automatic test_miss_with_younger();
    int reqs;
    int prev;
    reqs = req_count;
    // younger fetch hits a resident block
    fetch(32'h0000_3350);
    prev = last_accept_cycle;
    fetch(32'h0000_1234);
    check_eq("accept spacing", last_accept_cycle - prev, 1);
    drain();
    // younger fetch misses in another set
    fetch(32'h0000_4460);
    fetch(32'h0000_5570);
    drain();
    // younger fetch in the block being filled
    fetch(32'h0000_668c);
    fetch(32'h0000_6680);
    drain();
    check_eq("mem_req_o count", req_count - reqs, 4);
  endtask

  task automatic test_replacement();
    addr_t blk[5];
    int    reqs;
    for (int i = 0; i < 5; i++) begin
      blk[i] = 32'h0000_a090 + addr_t'(i * 32'h1000);
    end
    reqs = req_count;
    // set 9 starts empty so fills land in ways 0 to 3 and leave the tree at 000
    for (int i = 0; i < 4; i++) begin
      fetch(blk[i]);
      drain();
    end
    check_eq("mem_req_o count", req_count - reqs, 4);
    // hits on ways 0 and 2 give bit0=0, bit1=1, bit2=1 so the victim is way 1
    fetch(blk[0]);
    fetch(blk[2]);
    drain();
    reqs = req_count;
    fetch(blk[4]);
    drain();
    check_eq("mem_req_o count", req_count - reqs, 1);
    reqs = req_count;
    fetch(blk[0] + 32'h4);
    fetch(blk[2] + 32'h8);
    fetch(blk[3] + 32'hc);
    fetch(blk[4] + 32'h4);
    drain();
    check_eq("mem_req_o count", req_count - reqs, 0);
    fetch(blk[1]);
    drain();
    check_eq("mem_req_o count", req_count - reqs, 1);
    check_eq("mem_addr_o", last_req_addr, blk[1]);
  endtask

  task automatic test_miss_burst();
    int reqs;
    reqs = req_count;
    for (int i = 0; i < 6; i++) begin
      fetch(32'h0000_7004 + addr_t'(i * 32'h110));
    end
    drain();
    check_eq("mem_req_o count", req_count - reqs, 6);
  endtask

  initial begin : main
    fetch_v = 1'b0;
    fetch_addr = '0;
    last_accept_cycle = 0;
    @(negedge clk);
    while (reset) @(negedge clk);
    test_reset_state();
    test_cold_miss_then_hit();
    test_back_to_back();
    test_miss_with_younger();
    test_replacement();
    test_miss_burst();
    $display("sim passed");
    $finish;
  end

endmodule

/* project.f */
hw/icache_pkg.sv
hw/icache_tag_array.sv
hw/icache_data_array.sv
hw/icache_plru.sv
hw/icache_ctrl.sv
hw/icache_top.sv
tb/tb_clock_gen.sv
tb/tb_icache.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the instruction cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f project.f --top-module tb_icache -o tb_icache_sim

out=$(./obj_dir/tb_icache_sim 2>&1 || true)
echo "$out"

if echo "$out" | grep -q "^sim passed$"; then
  exit 0
fi
exit 1
